// File: Makefile
SRCS := $(shell cat project.f)

all: run

obj_dir/Vtb_ex_stage: project.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_ex_stage -f project.f

run: obj_dir/Vtb_ex_stage
	./obj_dir/Vtb_ex_stage

clean:
	rm -rf obj_dir

.PHONY: all run clean

// File: ex_bundle_if.sv
interface ex_bundle_if #(
    parameter int XLEN = 64
);

    // Operands after forwarding and immediate select
    logic [XLEN-1:0] value1;
    logic [XLEN-1:0] value2;
    logic            accept;

    // ALU outputs
    logic [XLEN-1:0] result;
    logic            update_rd;
    logic            is_load;

    modport fwd (output value1, output value2, output accept);

    modport alu (input value1, input value2, output result, output update_rd, output is_load);

    modport pipe (
        input value1, input value2, input accept,
        input result, input update_rd, input is_load
    );

endinterface

// File: ex_op_pkg.sv
package ex_op_pkg;

    // Encoded execute operation
    // OP_NOP must stay at zero so that a flushed slot reads as a bubble
    typedef enum logic [4:0] {
        OP_NOP   = 5'd0,
        OP_ADD   = 5'd1,
        OP_SUB   = 5'd2,
        OP_SLL   = 5'd3,
        OP_SLT   = 5'd4,
        OP_SLTU  = 5'd5,
        OP_XOR   = 5'd6,
        OP_SRL   = 5'd7,
        OP_SRA   = 5'd8,
        OP_OR    = 5'd9,
        OP_AND   = 5'd10,
        // 32-bit word forms
        OP_ADDW  = 5'd11,
        OP_SUBW  = 5'd12,
        OP_SLLW  = 5'd13,
        OP_SRLW  = 5'd14,
        OP_SRAW  = 5'd15,
        OP_LUI   = 5'd16,
        // Address generation for memory access
        OP_LOAD  = 5'd17,
        OP_STORE = 5'd18
    } ex_op_e;

endpackage

// File: ex_pipe_reg.sv
module ex_pipe_reg
    import rv_reg_pkg::*;
    import ex_op_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            branch_taken,
    input  regno_t          rd_regno,
    input  ex_op_e          op,
    input  logic [XLEN-1:0] fwd_rs2,
    ex_bundle_if.pipe       bus,
    output logic [XLEN-1:0] out_alu_result,
    output logic [XLEN-1:0] out_rs2_value,
    output regno_t          out_rd_regno,
    output ex_op_e          out_op,
    output logic            out_update_rd,
    output logic            out_mm_load
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_alu_result <= '0;
            out_rs2_value  <= '0;
            out_rd_regno   <= REG_ZERO;
            out_op         <= OP_NOP;
            out_update_rd  <= 1'b0;
            out_mm_load    <= 1'b0;
        end
        else if (bus.accept)
        begin
            if (branch_taken)
            begin
                // Squash into a bubble
                out_alu_result <= '0;
                out_rs2_value  <= '0;
                out_rd_regno   <= REG_ZERO;
                out_op         <= OP_NOP;
                out_update_rd  <= 1'b0;
                out_mm_load    <= 1'b0;
            end
            else
            begin
                out_alu_result <= bus.result;
                out_rs2_value  <= fwd_rs2;
                out_rd_regno   <= rd_regno;
                out_op         <= op;
                out_update_rd  <= bus.update_rd;
                out_mm_load    <= bus.is_load;
            end
        end
    end

endmodule

// File: ex_stage_assert.sv
module ex_stage_assert
    import rv_reg_pkg::*;
    import ex_op_pkg::*;
#(
    parameter int XLEN = 64
) (
    input logic            clk,
    input logic            reset,
    input logic            enable,
    input logic            branch_taken,
    input logic            ready,
    input logic [XLEN-1:0] out_alu_result,
    input logic [XLEN-1:0] out_rs2_value,
    input regno_t          out_rd_regno,
    input ex_op_e          out_op,
    input logic            out_update_rd,
    input logic            out_mm_load
);

    logic accept;

    assign accept = enable && ready;

    ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> ready)
        else $error("ready low in the first cycle after reset");

    // A load-use stall lasts one cycle only
    single_stall: assert property (@(posedge clk) disable iff (reset)
        (enable && !ready) |=> (!enable || ready))
        else $error("ready low on two consecutive cycles");

    hold_outputs: assert property (@(posedge clk) disable iff (reset)
        !accept |=> ($stable(out_alu_result) && $stable(out_rs2_value)
            && $stable(out_rd_regno) && $stable(out_op)
            && $stable(out_update_rd) && $stable(out_mm_load)))
        else $error("outputs changed without an accept");

    flush_no_write: assert property (@(posedge clk) disable iff (reset)
        (accept && branch_taken) |=> !out_update_rd)
        else $error("flushed instruction still writes rd");

endmodule

bind ex_stage_top ex_stage_assert #(.XLEN(XLEN)) i_assert (.*);

// File: ex_stage_top.sv
module ex_stage_top
    import rv_reg_pkg::*;
    import ex_op_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            enable,
    input  regno_t          rs1_regno,
    input  regno_t          rs2_regno,
    input  regno_t          rd_regno,
    input  logic [XLEN-1:0] rs1_value,
    input  logic [XLEN-1:0] rs2_value,
    input  logic [XLEN-1:0] imm_value,
    input  logic            use_imm,
    input  ex_op_e          op,
    input  regno_t          alu_rd_regno,
    input  regno_t          mm_rd_regno,
    input  regno_t          wb_rd_regno,
    input  logic            alu_load,
    input  logic [XLEN-1:0] alu_result,
    input  logic [XLEN-1:0] mm_data,
    input  logic [XLEN-1:0] wb_data,
    input  logic            branch_taken,
    output logic            ready,
    output logic [XLEN-1:0] out_alu_result,
    output logic [XLEN-1:0] out_rs2_value,
    output regno_t          out_rd_regno,
    output ex_op_e          out_op,
    output logic            out_update_rd,
    output logic            out_mm_load
);

    logic [XLEN-1:0] fwd_rs2;

    ex_bundle_if #(.XLEN(XLEN)) bus ();

    operand_forward #(.XLEN(XLEN)) i_forward (
        .clk          (clk),
        .reset        (reset),
        .enable       (enable),
        .rs1_regno    (rs1_regno),
        .rs2_regno    (rs2_regno),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .imm_value    (imm_value),
        .use_imm      (use_imm),
        .alu_rd_regno (alu_rd_regno),
        .mm_rd_regno  (mm_rd_regno),
        .wb_rd_regno  (wb_rd_regno),
        .alu_load     (alu_load),
        .alu_result   (alu_result),
        .mm_data      (mm_data),
        .wb_data      (wb_data),
        .ready        (ready),
        .fwd_rs2      (fwd_rs2),
        .bus          (bus.fwd)
    );

    int_alu #(.XLEN(XLEN)) i_alu (
        .op        (op),
        .imm_value (imm_value),
        .bus       (bus.alu)
    );

    ex_pipe_reg #(.XLEN(XLEN)) i_pipe (
        .clk            (clk),
        .reset          (reset),
        .branch_taken   (branch_taken),
        .rd_regno       (rd_regno),
        .op             (op),
        .fwd_rs2        (fwd_rs2),
        .bus            (bus.pipe),
        .out_alu_result (out_alu_result),
        .out_rs2_value  (out_rs2_value),
        .out_rd_regno   (out_rd_regno),
        .out_op         (out_op),
        .out_update_rd  (out_update_rd),
        .out_mm_load    (out_mm_load)
    );

endmodule

// File: int_alu.sv
module int_alu
    import ex_op_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  ex_op_e          op,
    input  logic [XLEN-1:0] imm_value,
    ex_bundle_if.alu        bus
);

    localparam int SHW = $clog2(XLEN);

    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [SHW-1:0]  shamt;
    logic [4:0]      shamt_w;
    logic [31:0]     word;

    function automatic logic [XLEN-1:0] sext32(input logic [31:0] w);
        return {{(XLEN-32){w[31]}}, w};
    endfunction

    assign a       = bus.value1;
    assign b       = bus.value2;
    assign shamt   = b[SHW-1:0];
    assign shamt_w = b[4:0];

    // 32-bit part of the word forms
    always_comb
    begin
        case (op)
            OP_ADDW: word = a[31:0] + b[31:0];
            OP_SUBW: word = a[31:0] - b[31:0];
            OP_SLLW: word = a[31:0] << shamt_w;
            OP_SRLW: word = a[31:0] >> shamt_w;
            OP_SRAW: word = $signed(a[31:0]) >>> shamt_w;
            default: word = '0;
        endcase
    end

    always_comb
    begin
        case (op)
            OP_ADD:   bus.result = a + b;
            OP_SUB:   bus.result = a - b;
            OP_SLL:   bus.result = a << shamt;
            OP_SLT:   bus.result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            OP_SLTU:  bus.result = {{(XLEN-1){1'b0}}, a < b};
            OP_XOR:   bus.result = a ^ b;
            OP_SRL:   bus.result = a >> shamt;
            OP_SRA:   bus.result = $signed(a) >>> shamt;
            OP_OR:    bus.result = a | b;
            OP_AND:   bus.result = a & b;
            OP_ADDW,
            OP_SUBW,
            OP_SLLW,
            OP_SRLW,
            OP_SRAW:  bus.result = sext32(word);
            OP_LUI:   bus.result = imm_value;
            // Effective address from b, which already holds the immediate
            OP_LOAD,
            OP_STORE: bus.result = a + b;
            default:  bus.result = '0;
        endcase
    end

    assign bus.update_rd = !(op inside {OP_NOP, OP_LOAD, OP_STORE});
    assign bus.is_load   = (op == OP_LOAD);

endmodule

// File: operand_forward.sv
module operand_forward
    import rv_reg_pkg::*;
#(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            enable,
    input  regno_t          rs1_regno,
    input  regno_t          rs2_regno,
    input  logic [XLEN-1:0] rs1_value,
    input  logic [XLEN-1:0] rs2_value,
    input  logic [XLEN-1:0] imm_value,
    input  logic            use_imm,
    input  regno_t          alu_rd_regno,
    input  regno_t          mm_rd_regno,
    input  regno_t          wb_rd_regno,
    input  logic            alu_load,
    input  logic [XLEN-1:0] alu_result,
    input  logic [XLEN-1:0] mm_data,
    input  logic [XLEN-1:0] wb_data,
    output logic            ready,
    output logic [XLEN-1:0] fwd_rs2,
    ex_bundle_if.fwd        bus
);

    logic            stall;
    logic            hazard1;
    logic            hazard2;
    logic [XLEN-1:0] fwd_rs1;

    // Youngest producer wins; a load in the ALU stage only has its data
    // once it has moved on to the memory stage
    function automatic logic [XLEN-1:0] forward(input regno_t src, input logic [XLEN-1:0] rf);
        if (src == REG_ZERO)
            return rf;
        else if (src == alu_rd_regno && alu_load)
            return mm_data;
        else if (src == alu_rd_regno)
            return alu_result;
        else if (src == mm_rd_regno)
            return mm_data;
        else if (src == wb_rd_regno)
            return wb_data;
        else
            return rf;
    endfunction

    assign hazard1 = (rs1_regno != REG_ZERO) && (rs1_regno == alu_rd_regno) && alu_load;
    assign hazard2 = (rs2_regno != REG_ZERO) && (rs2_regno == alu_rd_regno) && alu_load;

    // Hold off one cycle for the load data, then go
    assign ready = !((hazard1 || hazard2) && !stall);

    always_comb
    begin
        fwd_rs1 = forward(rs1_regno, rs1_value);
        fwd_rs2 = forward(rs2_regno, rs2_value);
    end

    assign bus.value1 = fwd_rs1;
    assign bus.value2 = use_imm ? imm_value : fwd_rs2;
    assign bus.accept = enable && ready;

    always_ff @(posedge clk)
    begin
        if (reset)
            stall <= 1'b0;
        else if (enable)
            stall <= !ready;
    end

endmodule

// File: project.f
rv_reg_pkg.sv
ex_op_pkg.sv
ex_bundle_if.sv
operand_forward.sv
int_alu.sv
ex_pipe_reg.sv
ex_stage_top.sv
ex_stage_assert.sv
tb_ex_stage.sv

// File: rv_reg_pkg.sv
package rv_reg_pkg;

    // Width of a register number
    localparam int REGNO_W = 5;

    typedef logic [REGNO_W-1:0] regno_t;

    // x0 reads as zero and is never a forwarding source
    localparam regno_t REG_ZERO = regno_t'(0);

endpackage

// File: tb_ex_stage.sv
module tb_ex_stage
    import rv_reg_pkg::*;
    import ex_op_pkg::*;
#(
    parameter int XLEN = 64
);

    localparam int NUM_INSTR = 3000;
    localparam int TIMEOUT   = 20 * NUM_INSTR * 10;
    localparam int SHW       = $clog2(XLEN);

    logic            clk;
    logic            reset;
    logic            enable;
    regno_t          rs1_regno;
    regno_t          rs2_regno;
    regno_t          rd_regno;
    logic [XLEN-1:0] rs1_value;
    logic [XLEN-1:0] rs2_value;
    logic [XLEN-1:0] imm_value;
    logic            use_imm;
    ex_op_e          op;
    regno_t          alu_rd_regno;
    regno_t          mm_rd_regno;
    regno_t          wb_rd_regno;
    logic            alu_load;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] mm_data;
    logic [XLEN-1:0] wb_data;
    logic            branch_taken;
    logic            ready;
    logic [XLEN-1:0] out_alu_result;
    logic [XLEN-1:0] out_rs2_value;
    regno_t          out_rd_regno;
    ex_op_e          out_op;
    logic            out_update_rd;
    logic            out_mm_load;

    // Expected registered outputs of the model
    logic [XLEN-1:0] exp_result;
    logic [XLEN-1:0] exp_rs2;
    regno_t          exp_rd;
    ex_op_e          exp_op;
    logic            exp_upd;
    logic            exp_load;
    logic            stall_model;
    logic            accepted;
    int              n_accept;

    ex_stage_top #(.XLEN(XLEN)) i_dut (.*);

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] want);
        assert (got === want)
        else
        begin
            $display("[ERROR] %s: got %h, expected %h", name, got, want);
            abort_run();
        end
    endtask

    // Youngest producer first; a load in the ALU stage delivers through mm_data
    function automatic logic [XLEN-1:0] pick_source(input regno_t src,
                                                    input logic [XLEN-1:0] rf);
        if (src == REG_ZERO)
            return rf;
        if (src == alu_rd_regno)
            return alu_load ? mm_data : alu_result;
        if (src == mm_rd_regno)
            return mm_data;
        if (src == wb_rd_regno)
            return wb_data;
        return rf;
    endfunction

    function automatic logic [XLEN-1:0] sign_word(input logic [XLEN-1:0] v);
        return {{(XLEN-32){v[31]}}, v[31:0]};
    endfunction

    function automatic logic [XLEN-1:0] alu_model(input ex_op_e f, input logic [XLEN-1:0] a,
                                                  input logic [XLEN-1:0] b,
                                                  input logic [XLEN-1:0] imm);
        logic [XLEN-1:0] top;
        logic [SHW-1:0]  sh;
        logic [4:0]      shw;
        logic [31:0]     lw;
        logic            lt_s;
        logic            lt_u;
        top  = {1'b1, {(XLEN-1){1'b0}}};
        sh   = b[SHW-1:0];
        shw  = b[4:0];
        lw   = a[31:0];
        // Signed compare by flipping the sign bits
        lt_s = (a ^ top) < (b ^ top);
        lt_u = a < b;
        case (f)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_SLL:   return a << sh;
            OP_SLT:   return XLEN'(lt_s);
            OP_SLTU:  return XLEN'(lt_u);
            OP_XOR:   return a ^ b;
            OP_SRL:   return a >> sh;
            OP_SRA:   return (a >> sh) | (a[XLEN-1] ? ~({XLEN{1'b1}} >> sh) : '0);
            OP_OR:    return a | b;
            OP_AND:   return a & b;
            OP_ADDW:  return sign_word(a + b);
            OP_SUBW:  return sign_word(a - b);
            OP_SLLW:  return sign_word(a << shw);
            OP_SRLW:  return sign_word(XLEN'(lw >> shw));
            OP_SRAW:  return sign_word(XLEN'((lw >> shw)
                                       | (lw[31] ? ~(32'hffffffff >> shw) : 32'h0)));
            OP_LUI:   return imm;
            OP_LOAD,
            OP_STORE: return a + b;
            default:  return '0;
        endcase
    endfunction

    task automatic check_outputs();
        check_value("out_alu_result", out_alu_result, exp_result);
        check_value("out_rs2_value", out_rs2_value, exp_rs2);
        check_value("out_rd_regno", XLEN'(out_rd_regno), XLEN'(exp_rd));
        check_value("out_op", XLEN'(out_op), XLEN'(exp_op));
        check_value("out_update_rd", XLEN'(out_update_rd), XLEN'(exp_upd));
        check_value("out_mm_load", XLEN'(out_mm_load), XLEN'(exp_load));
    endtask

    // Predicts ready for this cycle and the outputs after the next edge
    task automatic model_cycle();
        logic            hazard;
        logic            exp_ready;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] r2;
        hazard = alu_load && ((rs1_regno != REG_ZERO && rs1_regno == alu_rd_regno)
                 || (rs2_regno != REG_ZERO && rs2_regno == alu_rd_regno));
        exp_ready = !hazard || stall_model;
        check_value("ready", XLEN'(ready), XLEN'(exp_ready));
        accepted = enable && exp_ready;
        if (accepted)
        begin
            n_accept++;
            a = pick_source(rs1_regno, rs1_value);
            r2 = pick_source(rs2_regno, rs2_value);
            exp_result = '0;
            exp_rs2 = '0;
            exp_rd = REG_ZERO;
            exp_op = OP_NOP;
            exp_upd = 1'b0;
            exp_load = 1'b0;
            if (!branch_taken)
            begin
                exp_result = alu_model(op, a, use_imm ? imm_value : r2, imm_value);
                exp_rs2 = r2;
                exp_rd = rd_regno;
                exp_op = op;
                exp_upd = (op != OP_NOP) && (op != OP_LOAD) && (op != OP_STORE);
                exp_load = (op == OP_LOAD);
            end
        end
        if (enable)
            stall_model = !exp_ready;
    endtask

    task automatic drive_next();
        ex_op_e next_op;
        next_op = ex_op_e'(5'($urandom_range(0, 18)));
        enable       <= ($urandom_range(0, 99) < 85);
        op           <= next_op;
        use_imm      <= (next_op inside {OP_LUI, OP_LOAD, OP_STORE}) || ($urandom_range(0, 1) == 1);
        // Few register numbers so that forwarding matches often
        rs1_regno    <= regno_t'($urandom_range(0, 3));
        rs2_regno    <= regno_t'($urandom_range(0, 3));
        rd_regno     <= regno_t'($urandom_range(0, 3));
        alu_rd_regno <= regno_t'($urandom_range(0, 3));
        mm_rd_regno  <= regno_t'($urandom_range(0, 3));
        wb_rd_regno  <= regno_t'($urandom_range(0, 3));
        alu_load     <= ($urandom_range(0, 3) == 0);
        branch_taken <= ($urandom_range(0, 9) == 0);
        rs1_value    <= {$urandom, $urandom};
        rs2_value    <= {$urandom, $urandom};
        imm_value    <= {$urandom, $urandom};
        alu_result   <= {$urandom, $urandom};
        mm_data      <= {$urandom, $urandom};
        wb_data      <= {$urandom, $urandom};
    endtask

    initial
    begin
        void'($urandom(32'h08e409c1));
        clk = 1'b0;
        reset = 1'b1;
        enable = 1'b0;
        rs1_regno = REG_ZERO;
        rs2_regno = REG_ZERO;
        rd_regno = REG_ZERO;
        rs1_value = '0;
        rs2_value = '0;
        imm_value = '0;
        use_imm = 1'b0;
        op = OP_NOP;
        alu_rd_regno = REG_ZERO;
        mm_rd_regno = REG_ZERO;
        wb_rd_regno = REG_ZERO;
        alu_load = 1'b0;
        alu_result = '0;
        mm_data = '0;
        wb_data = '0;
        branch_taken = 1'b0;
        exp_result = '0;
        exp_rs2 = '0;
        exp_rd = REG_ZERO;
        exp_op = OP_NOP;
        exp_upd = 1'b0;
        exp_load = 1'b0;
        stall_model = 1'b0;
        accepted = 1'b0;
        n_accept = 0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        while (n_accept < NUM_INSTR)
        begin
            @(negedge clk);
            check_outputs();
            model_cycle();
            @(posedge clk);
            // Inputs stay put while the stage holds off
            if (accepted || !enable)
                drive_next();
        end
        @(negedge clk);
        check_outputs();
        $display("Finished with no errors");
        $finish;
    end

    initial
    begin
        #(TIMEOUT);
        $display("Timeout: the stage accepted fewer than %0d instructions", NUM_INSTR);
        abort_run();
    end

endmodule
